//--- tb/frontend_testdata.txt
// first 32 words: memory image starting at bfc00000
// then one test per line: id start pairs addr_max data_max stall mid_off mid_target expected
24010001 24220002 00221821 34040005 8c850000 ace60004 00000000 3c08bfc0
25080010 01095021 240b0007 016c6825 8d0e0000 01cf7821 35100003 ae110008
24120001 26520001 26520001 00000000 24130002 24140003 02749020 1000ffff
3c15a000 36b50010 8eb60000 02d6b821 24180004 24190005 0319c022 00000000
// sequential order from an aligned start, no delays
00000001 bfc00000 00000018 00000000 00000000 00000000 00000000 00000000 00000020
// pairing rule over dependent neighbors
00000002 bfc00010 00000014 00000002 00000003 00000004 00000000 00000000 00000018
// upper-word start
00000003 bfc00014 00000008 00000001 00000002 00000000 00000000 00000000 00000008
// redirect mid-stream with a response in flight
00000004 bfc00000 00000010 00000003 00000004 00000000 00000006 bfc00040 00000010
// misaligned target
00000005 bfc00022 00000004 00000001 00000001 00000000 00000000 00000000 00000001
// dense stalls and long bus delays
00000006 bfc00008 00000040 00000006 00000008 0000000c 00000000 00000000 00000020

//--- verilog.f
design/frontend_pkg.sv
design/fetch_slot_if.sv
design/queue_pop_if.sv
design/fetch_unit.sv
design/fetch_queue.sv
design/issue_unit.sv
design/frontend_top.sv
tb/frontend_props.sv
tb/frontend_checker.sv
tb/frontend_tb.sv

//--- Bender.yml
package:
  name: frontend

sources:
  - design/frontend_pkg.sv
  - design/fetch_slot_if.sv
  - design/queue_pop_if.sv
  - design/fetch_unit.sv
  - design/fetch_queue.sv
  - design/issue_unit.sv
  - design/frontend_top.sv
  - target: simulation
    files:
      - tb/frontend_props.sv
      - tb/frontend_checker.sv
      - tb/frontend_tb.sv

//--- tb/frontend_tb.sv
`timescale 1ns/1ns

module frontend_tb;

    localparam int IMAGE_WORDS = 32;
    localparam int NUM_TESTS   = 6;
    localparam int REC_WORDS   = 9;

    logic                     clk;
    logic                     reset;
    logic                     ireq_valid;
    frontend_pkg::word_t      ireq_addr;
    logic                     iresp_addr_ok;
    logic                     iresp_data_ok;
    frontend_pkg::ibus_data_t iresp_data;
    logic                     redirect_valid;
    frontend_pkg::word_t      redirect_pc;
    logic                     issue_stall;
    logic [1:0]               issue_valid;
    frontend_pkg::word_t      issue_pc0;
    frontend_pkg::word_t      issue_instr0;
    frontend_pkg::word_t      issue_pc1;
    frontend_pkg::word_t      issue_instr1;
    logic                     issue_exc;

    frontend_pkg::word_t tdata [IMAGE_WORDS + NUM_TESTS * REC_WORDS];
    frontend_pkg::word_t image [IMAGE_WORDS];
    frontend_pkg::word_t lat_addr;
    integer              seed;
    int                  addr_max;
    int                  data_max;
    int                  stall_density;
    int                  a_cnt;
    int                  d_cnt;
    logic                busy;
    int                  limit;
    int                  cycles;
    logic                test_done;
    int                  test_id;
    int                  issued;
    int                  errors;
    int                  tests_passed;
    int                  tests_failed;

    frontend_top u_dut (.*);

    frontend_checker u_chk (.*);

    bind frontend_top frontend_props u_props (.*);

    function automatic frontend_pkg::word_t fetch_word(input frontend_pkg::word_t a);
        frontend_pkg::word_t off;
        off = a - frontend_pkg::RESET_PC;
        return (off < 32'd128) ? image[off[6:2]] : 32'd0;
    endfunction

    function automatic int rand_delay(input int max);
        return $unsigned($random(seed)) % (max + 1);
    endfunction

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // bus memory model with one outstanding request
    always @(posedge clk) begin
        if (reset) begin
            iresp_addr_ok <= 1'b0;
            iresp_data_ok <= 1'b0;
            busy          <= 1'b0;
            issue_stall   <= 1'b0;
        end else begin
            issue_stall   <= ($random(seed) & 15) < stall_density;
            iresp_data_ok <= 1'b0;
            if (ireq_valid && iresp_addr_ok) begin
                iresp_addr_ok <= 1'b0;
                lat_addr      <= ireq_addr;
                d_cnt         <= rand_delay(data_max);
                busy          <= 1'b1;
            end else if (ireq_valid) begin
                if (a_cnt == 0) begin
                    iresp_addr_ok <= 1'b1;
                end else begin
                    a_cnt <= a_cnt - 1;
                end
            end else begin
                iresp_addr_ok <= 1'b0;
                a_cnt         <= rand_delay(addr_max);
            end
            if (busy) begin
                if (d_cnt == 0) begin
                    iresp_data_ok <= 1'b1;
                    iresp_data    <= {fetch_word(lat_addr + 32'd4), fetch_word(lat_addr)};
                    busy          <= 1'b0;
                end else begin
                    d_cnt <= d_cnt - 1;
                end
            end
        end
    end

    task automatic run_test(input int base);
        int   waited;
        logic finished;
        @(posedge clk);
        test_id        <= tdata[base];
        redirect_valid <= 1'b1;
        redirect_pc    <= tdata[base + 1];
        addr_max       <= tdata[base + 3];
        data_max       <= tdata[base + 4];
        stall_density  <= tdata[base + 5];
        waited   = 0;
        finished = 1'b0;
        while (!finished) begin
            @(posedge clk);
            waited++;
            if (tdata[base + 6] != 0 && waited == tdata[base + 6]) begin
                redirect_valid <= 1'b1;
                redirect_pc    <= tdata[base + 7];
            end else begin
                redirect_valid <= 1'b0;
            end
            @(negedge clk);
            finished = waited > tdata[base + 6] + 1 && issued >= tdata[base + 8];
        end
        // quiet tail catches anything issued after an exception slot
        repeat (8) @(posedge clk);
        test_done <= 1'b1;
        @(posedge clk);
        test_done <= 1'b0;
    endtask

    initial begin
        $readmemh("tb/frontend_testdata.txt", tdata);
        for (int i = 0; i < IMAGE_WORDS; i++) begin
            image[i] = tdata[i];
        end
        limit = 100;
        for (int t = 0; t < NUM_TESTS; t++) begin
            limit += tdata[IMAGE_WORDS + t * REC_WORDS + 2] *
                     (tdata[IMAGE_WORDS + t * REC_WORDS + 3] +
                      tdata[IMAGE_WORDS + t * REC_WORDS + 4] + 4);
        end
        seed           = 44139;
        reset          = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        iresp_addr_ok  = 1'b0;
        iresp_data_ok  = 1'b0;
        iresp_data     = '0;
        issue_stall    = 1'b0;
        addr_max       = 0;
        data_max       = 0;
        stall_density  = 0;
        test_done      = 1'b0;
        test_id        = 0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(IMAGE_WORDS + t * REC_WORDS);
        end
        repeat (2) @(posedge clk);
        $display("tests passed %0d, tests failed %0d, errors %0d, assertion failures %0d",
                 tests_passed, tests_failed, errors, u_dut.u_props.fail_count);
        if (tests_failed == 0 && errors == 0 && u_dut.u_props.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        wait (limit > 0);
        while (cycles <= limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the tests did not finish within %0d cycles", limit);
        $display("sim failed");
        $finish;
    end

endmodule

//--- tb/frontend_checker.sv
`timescale 1ns/1ns

module frontend_checker (
    input  logic                clk,
    input  logic                reset,
    input  logic                redirect_valid,
    input  frontend_pkg::word_t redirect_pc,
    input  logic                issue_stall,
    input  logic [1:0]          issue_valid,
    input  frontend_pkg::word_t issue_pc0,
    input  frontend_pkg::word_t issue_instr0,
    input  frontend_pkg::word_t issue_pc1,
    input  frontend_pkg::word_t issue_instr1,
    input  logic                issue_exc,
    input  frontend_pkg::word_t image [32],
    input  logic                test_done,
    input  int                  test_id,
    output int                  issued,
    output int                  errors,
    output int                  tests_passed,
    output int                  tests_failed
);

    frontend_pkg::word_t exp_pc;
    logic                halted;
    logic                hold;
    logic [1:0]          held_valid;
    logic                held_exc;
    frontend_pkg::word_t held_pc0;
    frontend_pkg::word_t held_instr0;
    frontend_pkg::word_t held_pc1;
    frontend_pkg::word_t held_instr1;
    int                  errs_at_start;

    // opcode 0 writes rd, 0x08-0x0f and 0x20-0x27 write rt
    function automatic frontend_pkg::reg_idx_t write_target(input frontend_pkg::word_t w);
        if (w[31:26] == 6'h00) begin
            return w[15:11];
        end
        if (w[31:29] == 3'b001 || w[31:29] == 3'b100) begin
            return w[20:16];
        end
        return 5'd0;
    endfunction

    function automatic frontend_pkg::word_t image_word(input frontend_pkg::word_t a);
        frontend_pkg::word_t off;
        off = a - frontend_pkg::RESET_PC;
        if (off < 32'd128) begin
            return image[off[6:2]];
        end
        return '0;
    endfunction

    task automatic check_slot(input frontend_pkg::word_t pc, input frontend_pkg::word_t instr,
                              input logic exc);
        frontend_pkg::word_t want;
        if (halted) begin
            $display("error at %0t: pc %h issued after the exception slot", $time, pc);
            errors++;
            return;
        end
        // misaligned target gives one exception slot, then silence
        want = (exp_pc[1:0] != 2'b00) ? 32'd0 : image_word(exp_pc);
        if (pc !== exp_pc || instr !== want || exc !== (exp_pc[1:0] != 2'b00)) begin
            $display("[FAIL] %0t: expected pc %h instr %h, got pc %h instr %h exc %b",
                     $time, exp_pc, want, pc, instr, exc);
            errors++;
        end
        halted = exp_pc[1:0] != 2'b00;
        exp_pc = exp_pc + 32'd4;
        issued++;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            exp_pc = frontend_pkg::RESET_PC;
            halted = 1'b0;
            hold   = 1'b0;
            issued = 0;
        end else begin
            if (hold && (issue_valid !== held_valid || issue_exc !== held_exc ||
                         issue_pc0 !== held_pc0 || issue_instr0 !== held_instr0 ||
                         issue_pc1 !== held_pc1 || issue_instr1 !== held_instr1)) begin
                $display("[FAIL] %0t: issue outputs changed while stalled", $time);
                errors++;
            end
            hold        = issue_stall && !redirect_valid;
            held_valid  = issue_valid;
            held_exc    = issue_exc;
            held_pc0    = issue_pc0;
            held_instr0 = issue_instr0;
            held_pc1    = issue_pc1;
            held_instr1 = issue_instr1;
            // outputs are consumed at an edge without stall
            if (!issue_stall && issue_valid[0]) begin
                check_slot(issue_pc0, issue_instr0, issue_exc);
                if (issue_valid[1]) begin
                    if (write_target(issue_instr0) != 5'd0 &&
                        (issue_instr1[25:21] == write_target(issue_instr0) ||
                         issue_instr1[20:16] == write_target(issue_instr0))) begin
                        $display("[FAIL] %0t: pc %h paired with dependent pc %h",
                                 $time, issue_pc0, issue_pc1);
                        errors++;
                    end
                    check_slot(issue_pc1, issue_instr1, 1'b0);
                end
            end
            if (redirect_valid) begin
                exp_pc = redirect_pc;
                halted = 1'b0;
                issued = 0;
            end
            if (test_done) begin
                if (errors == errs_at_start) begin
                    tests_passed++;
                    $display("test %0d passed, %0d instructions issued", test_id, issued);
                end else begin
                    tests_failed++;
                    $display("test %0d failed with %0d errors", test_id,
                             errors - errs_at_start);
                end
                errs_at_start = errors;
            end
        end
    end

    initial begin
        errors        = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        errs_at_start = 0;
    end

endmodule

//--- tb/frontend_props.sv
`timescale 1ns/1ns

module frontend_props (
    input logic                clk,
    input logic                reset,
    input logic                ireq_valid,
    input logic                iresp_addr_ok,
    input frontend_pkg::word_t ireq_addr,
    input logic [1:0]          issue_valid,
    input logic                issue_exc
);

    // count of failed assertions
    int fail_count = 0;

    // a waiting request keeps its address until accepted or withdrawn
    addr_stable: assert property (@(posedge clk) disable iff (reset)
        ireq_valid && !iresp_addr_ok |=> !ireq_valid || $stable(ireq_addr))
        else begin
            $error("ireq_addr changed while the request waited for addr_ok");
            fail_count++;
        end

    quiet_after_reset: assert property (@(posedge clk) reset |=> !ireq_valid)
        else begin
            $error("ireq_valid high in the cycle after reset");
            fail_count++;
        end

    slot_order: assert property (@(posedge clk) disable iff (reset)
        issue_valid[1] |-> issue_valid[0])
        else begin
            $error("issue slot 1 valid without slot 0");
            fail_count++;
        end

    exc_alone: assert property (@(posedge clk) disable iff (reset)
        issue_exc |-> !issue_valid[1])
        else begin
            $error("exception slot issued together with a second slot");
            fail_count++;
        end

endmodule

//--- design/frontend_top.sv
`timescale 1ns/1ns

module frontend_top (
    input  logic                     clk,
    input  logic                     reset,

    // instruction bus
    output logic                     ireq_valid,
    output frontend_pkg::word_t      ireq_addr,
    input  logic                     iresp_addr_ok,
    input  logic                     iresp_data_ok,
    input  frontend_pkg::ibus_data_t iresp_data,

    // branch or exception target, one-cycle pulse
    input  logic                     redirect_valid,
    input  frontend_pkg::word_t      redirect_pc,

    input  logic                     issue_stall,
    output logic [1:0]               issue_valid,
    output frontend_pkg::word_t      issue_pc0,
    output frontend_pkg::word_t      issue_instr0,
    output frontend_pkg::word_t      issue_pc1,
    output frontend_pkg::word_t      issue_instr1,
    output logic                     issue_exc
);

    fetch_slot_if fetch_slots ();
    queue_pop_if  queue_head ();

    fetch_unit u_fetch (
        .clk            (clk),
        .reset          (reset),
        .ireq_valid     (ireq_valid),
        .ireq_addr      (ireq_addr),
        .iresp_addr_ok  (iresp_addr_ok),
        .iresp_data_ok  (iresp_data_ok),
        .iresp_data     (iresp_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .slots          (fetch_slots.producer)
    );

    // redirect empties the queue and the issue registers at the same edge
    fetch_queue u_queue (
        .clk   (clk),
        .reset (reset),
        .flush (redirect_valid),
        .push  (fetch_slots.consumer),
        .pop   (queue_head.source)
    );

    issue_unit u_issue (
        .clk          (clk),
        .reset        (reset),
        .flush        (redirect_valid),
        .issue_stall  (issue_stall),
        .head         (queue_head.sink),
        .issue_valid  (issue_valid),
        .issue_pc0    (issue_pc0),
        .issue_instr0 (issue_instr0),
        .issue_pc1    (issue_pc1),
        .issue_instr1 (issue_instr1),
        .issue_exc    (issue_exc)
    );

endmodule

//--- design/issue_unit.sv
`timescale 1ns/1ns

module issue_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  logic                issue_stall,
    queue_pop_if.sink           head,
    output logic [1:0]          issue_valid,
    output frontend_pkg::word_t issue_pc0,
    output frontend_pkg::word_t issue_instr0,
    output frontend_pkg::word_t issue_pc1,
    output frontend_pkg::word_t issue_instr1,
    output logic                issue_exc
);

    frontend_pkg::reg_idx_t dest0;
    frontend_pkg::reg_idx_t src_rs1;
    frontend_pkg::reg_idx_t src_rt1;
    logic                   raw_hazard;
    logic                   take0;
    logic                   take1;

    assign dest0   = frontend_pkg::dest_reg(head.instr0);
    assign src_rs1 = head.instr1[25:21];
    assign src_rt1 = head.instr1[20:16];

    // r0 is never a real dependency
    assign raw_hazard = (dest0 != '0) && (src_rs1 == dest0 || src_rt1 == dest0);

    // oldest slot goes whenever there is one
    assign take0 = !issue_stall && head.head_count != 2'd0;

    // second slot pairs only with a clean, independent first slot
    assign take1 = take0 && head.head_count == 2'd2 && !head.exc0 && !head.exc1 &&
                   !raw_hazard;

    assign head.pop_count = take1 ? 2'd2 : (take0 ? 2'd1 : 2'd0);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            issue_valid <= 2'b00;
            issue_exc   <= 1'b0;
        end else if (!issue_stall) begin
            issue_valid <= {take1, take0};
            issue_exc   <= take0 && head.exc0;
        end
    end

    // payload holds while stalled since nothing is taken then
    always_ff @(posedge clk) begin
        if (take0) begin
            issue_pc0    <= head.pc0;
            issue_instr0 <= head.instr0;
        end
        if (take1) begin
            issue_pc1    <= head.pc1;
            issue_instr1 <= head.instr1;
        end
    end

endmodule

//--- design/fetch_queue.sv
`timescale 1ns/1ns

module fetch_queue (
    input  logic           clk,
    input  logic           reset,
    input  logic           flush,
    fetch_slot_if.consumer push,
    queue_pop_if.source    pop
);

    frontend_pkg::word_t   pc_mem    [frontend_pkg::QUEUE_DEPTH];
    frontend_pkg::word_t   instr_mem [frontend_pkg::QUEUE_DEPTH];
    logic                  exc_mem   [frontend_pkg::QUEUE_DEPTH];

    frontend_pkg::qptr_t   rd_ptr;
    frontend_pkg::qptr_t   wr_ptr;
    frontend_pkg::qptr_t   rd_ptr_1;
    frontend_pkg::qptr_t   wr_ptr_1;
    frontend_pkg::qcount_t count;

    // second slot positions, wrap comes free with a power-of-two depth
    assign rd_ptr_1 = rd_ptr + frontend_pkg::qptr_t'(1);
    assign wr_ptr_1 = wr_ptr + frontend_pkg::qptr_t'(1);

    assign push.free_count = frontend_pkg::qcount_t'(frontend_pkg::QUEUE_DEPTH) - count;

    assign pop.head_count = (count >= frontend_pkg::qcount_t'(2)) ? 2'd2 : count[1:0];
    assign pop.pc0        = pc_mem[rd_ptr];
    assign pop.instr0     = instr_mem[rd_ptr];
    assign pop.exc0       = exc_mem[rd_ptr];
    assign pop.pc1        = pc_mem[rd_ptr_1];
    assign pop.instr1     = instr_mem[rd_ptr_1];
    assign pop.exc1       = exc_mem[rd_ptr_1];

    // slot storage
    always_ff @(posedge clk) begin
        if (!flush && push.push_count != 2'd0) begin
            pc_mem[wr_ptr]    <= push.pc0;
            instr_mem[wr_ptr] <= push.instr0;
            exc_mem[wr_ptr]   <= push.exc0;
        end
        if (!flush && push.push_count == 2'd2) begin
            pc_mem[wr_ptr_1]    <= push.pc1;
            instr_mem[wr_ptr_1] <= push.instr1;
            // only a lone slot can carry an exception
            exc_mem[wr_ptr_1]   <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + frontend_pkg::qptr_t'(push.push_count);
            rd_ptr <= rd_ptr + frontend_pkg::qptr_t'(pop.pop_count);
            count  <= count + frontend_pkg::qcount_t'(push.push_count)
                            - frontend_pkg::qcount_t'(pop.pop_count);
        end
    end

endmodule

//--- design/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit (
    input  logic                     clk,
    input  logic                     reset,
    output logic                     ireq_valid,
    output frontend_pkg::word_t      ireq_addr,
    input  logic                     iresp_addr_ok,
    input  logic                     iresp_data_ok,
    input  frontend_pkg::ibus_data_t iresp_data,
    input  logic                     redirect_valid,
    input  frontend_pkg::word_t      redirect_pc,
    fetch_slot_if.producer           slots
);

    frontend_pkg::fetch_state_t state;
    frontend_pkg::word_t        pc;
    frontend_pkg::word_t        req_addr;
    logic                       discard;
    logic                       misaligned;
    logic                       room_for_pair;
    logic                       resp_taken;
    logic                       exc_push;

    assign misaligned    = pc[1:0] != 2'b00;
    assign room_for_pair = slots.free_count >= frontend_pkg::qcount_t'(2);

    // response to the current request, not a leftover from an old path
    assign resp_taken = (state == frontend_pkg::FETCH_WAIT) && iresp_data_ok && !discard;

    // misaligned target becomes a single exception slot
    assign exc_push = (state == frontend_pkg::FETCH_IDLE) && misaligned &&
                      (slots.free_count != '0);

    assign ireq_valid = state == frontend_pkg::FETCH_REQ;
    assign ireq_addr  = req_addr;

    // pc[1:0] is zero for every requested pc, so slot 0 always carries pc
    assign slots.pc0    = pc;
    assign slots.instr0 = !resp_taken ? '0 :
                          (pc[2] ? iresp_data[63:32] : iresp_data[31:0]);
    assign slots.exc0   = exc_push;
    assign slots.pc1    = {pc[31:3], 3'b100};
    assign slots.instr1 = iresp_data[63:32];

    always_comb begin
        slots.push_count = 2'd0;
        if (resp_taken) begin
            // upper-word start only wants the +4 half
            slots.push_count = pc[2] ? 2'd1 : 2'd2;
        end else if (exc_push) begin
            slots.push_count = 2'd1;
        end
    end

    // address follows pc while idle, frozen once the request is up
    always_ff @(posedge clk) begin
        if (state == frontend_pkg::FETCH_IDLE) begin
            req_addr <= {pc[31:3], 3'b000};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= frontend_pkg::FETCH_IDLE;
            pc      <= frontend_pkg::RESET_PC;
            discard <= 1'b0;
        end else if (redirect_valid) begin
            state <= frontend_pkg::FETCH_IDLE;
            pc    <= redirect_pc;
            // accepted request with data still to come gets its response dropped
            discard <= ((discard || state == frontend_pkg::FETCH_WAIT) && !iresp_data_ok) ||
                       (state == frontend_pkg::FETCH_REQ && iresp_addr_ok);
        end else begin
            if (discard && iresp_data_ok) begin
                discard <= 1'b0;
            end
            case (state)
                frontend_pkg::FETCH_IDLE: begin
                    if (misaligned) begin
                        if (exc_push) begin
                            state <= frontend_pkg::FETCH_HALT;
                        end
                    end else if (!discard && room_for_pair) begin
                        state <= frontend_pkg::FETCH_REQ;
                    end
                end
                frontend_pkg::FETCH_REQ: begin
                    if (iresp_addr_ok) begin
                        state <= frontend_pkg::FETCH_WAIT;
                    end
                end
                frontend_pkg::FETCH_WAIT: begin
                    if (resp_taken) begin
                        state <= frontend_pkg::FETCH_IDLE;
                        pc    <= {pc[31:3], 3'b000} + 32'd8;
                    end
                end
                default: begin
                    // halted until the next redirect
                    state <= frontend_pkg::FETCH_HALT;
                end
            endcase
        end
    end

endmodule

//--- design/queue_pop_if.sv
`timescale 1ns/1ns

interface queue_pop_if;
    // how many of the two head slots hold data
    logic [1:0]          head_count;
    frontend_pkg::word_t pc0;
    frontend_pkg::word_t instr0;
    logic                exc0;
    frontend_pkg::word_t pc1;
    frontend_pkg::word_t instr1;
    logic                exc1;

    // slots taken by the issue unit at this edge
    logic [1:0]          pop_count;

    modport source (
        output head_count, pc0, instr0, exc0, pc1, instr1, exc1,
        input  pop_count
    );

    modport sink (
        input  head_count, pc0, instr0, exc0, pc1, instr1, exc1,
        output pop_count
    );

endinterface

//--- design/fetch_slot_if.sv
`timescale 1ns/1ns

interface fetch_slot_if;
    // number of slots offered this cycle, slot 0 is the older one
    logic [1:0]            push_count;
    frontend_pkg::word_t   pc0;
    frontend_pkg::word_t   instr0;
    logic                  exc0;
    frontend_pkg::word_t   pc1;
    frontend_pkg::word_t   instr1;

    // space left in the queue
    frontend_pkg::qcount_t free_count;

    modport producer (
        output push_count, pc0, instr0, exc0, pc1, instr1,
        input  free_count
    );

    modport consumer (
        input  push_count, pc0, instr0, exc0, pc1, instr1,
        output free_count
    );

endinterface

//--- design/frontend_pkg.sv
package frontend_pkg;

    // one instruction word or one pc
    typedef logic [31:0] word_t;

    // pair returned by the instruction bus, low half is the 8-aligned word
    typedef logic [63:0] ibus_data_t;

    typedef logic [4:0] reg_idx_t;

    // occupancy and free space, 0 to 8
    typedef logic [3:0] qcount_t;

    localparam int QUEUE_DEPTH = 8;
    localparam int QPTR_W = $clog2(QUEUE_DEPTH);

    typedef logic [QPTR_W-1:0] qptr_t;

    localparam word_t RESET_PC = 32'hbfc0_0000;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_REQ,
        FETCH_WAIT,
        FETCH_HALT
    } fetch_state_t;

    // register written by an instruction, zero when it writes none
    // r-type writes rd, immediate alu ops and loads write rt
    // sources are always rs (25:21) and rt (20:16)
    function automatic reg_idx_t dest_reg(input word_t instr);
        logic [5:0] opcode;
        opcode = instr[31:26];
        if (opcode == 6'h00) begin
            return instr[15:11];
        end else if ((opcode >= 6'h08 && opcode <= 6'h0f) ||
                     (opcode >= 6'h20 && opcode <= 6'h27)) begin
            return instr[20:16];
        end
        return '0;
    endfunction

endpackage
